// ==== common/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // ==================================================
    // Seven-segment display
    // ==================================================

    // One hex digit.
    typedef logic [3:0] nibble_t;

    // Segment vector, active low. Bit 6 drives segment a and bit 0 drives
    // segment g, so the order from MSB down is a b c d e f g.
    typedef logic [6:0] seg_t;

    // All segments off.
    localparam seg_t SEG_BLANK = 7'b1111111;

endpackage

`default_nettype wire

// ==== common/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

    // ==================================================
    // PS/2 frame format
    // ==================================================

    // One frame is a start bit, eight data bits sent LSB first, an odd
    // parity bit and a stop bit. Each bit is taken on a falling ps2_clk edge.
    localparam int FRAME_BITS = 11;

    // One received scan code.
    typedef logic [7:0] scan_code_t;

    // Receiver FSM. DATA collects all FRAME_BITS samples after the first one
    // and CHECK lasts a single cycle.
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        CHECK
    } rx_state_t;

    // ==================================================
    // Scan code queue
    // ==================================================

    // Depth must stay a power of two so that the pointers wrap on their own.
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// ==== compile.f ====
common/ps2_pkg.sv
common/display_pkg.sv
ps2_rx/ps2_rx.sv
logic/scan_fifo.sv
logic/hex_display.sv
logic/ps2_keyboard_top.sv
tests/tb_ps2_keyboard.sv

// ==== logic/hex_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_display (
    input  wire                     clk,
    input  wire                     rst,
    input  ps2_pkg::scan_code_t     code,
    input  wire                     code_valid,
    output display_pkg::seg_t       seg_lo,
    output display_pkg::seg_t       seg_hi
);

    import display_pkg::*;

    nibble_t digit_lo;
    nibble_t digit_hi;

    // Glyphs in a b c d e f g order, a segment is lit when its bit is 0.
    function automatic seg_t hex_glyph(input nibble_t digit);
        case (digit)
            4'h0:    return 7'b0000001;
            4'h1:    return 7'b1001111;
            4'h2:    return 7'b0010010;
            4'h3:    return 7'b0000110;
            4'h4:    return 7'b1001100;
            4'h5:    return 7'b0100100;
            4'h6:    return 7'b0100000;
            4'h7:    return 7'b0001111;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0000100;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b1100000;
            4'hc:    return 7'b0110001;
            4'hd:    return 7'b1000010;
            4'he:    return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    assign digit_lo = code[3:0];
    assign digit_hi = code[7:4];

    // The head of the queue is only observed here, never popped.
    always_ff @(posedge clk) begin
        if (rst) begin
            seg_lo <= SEG_BLANK;
            seg_hi <= SEG_BLANK;
        end else if (code_valid) begin
            seg_lo <= hex_glyph(digit_lo);
            seg_hi <= hex_glyph(digit_hi);
        end else begin
            seg_lo <= SEG_BLANK;
            seg_hi <= SEG_BLANK;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ps2_keyboard_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 ps2_clk,
    input  wire                 ps2_data,
    output ps2_pkg::scan_code_t code,
    output logic                code_valid,
    input  wire                 code_ready,
    output logic                overflow,
    output logic                frame_error,
    output display_pkg::seg_t   seg_lo,
    output display_pkg::seg_t   seg_hi
);

    import ps2_pkg::*;

    scan_code_t rx_code;
    logic       rx_valid;

    ps2_rx ps2_rx_inst (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_code     (rx_code),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    scan_fifo scan_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .rx_code    (rx_code),
        .rx_valid   (rx_valid),
        .code       (code),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .overflow   (overflow)
    );

    hex_display hex_display_inst (
        .clk        (clk),
        .rst        (rst),
        .code       (code),
        .code_valid (code_valid),
        .seg_lo     (seg_lo),
        .seg_hi     (seg_hi)
    );

endmodule

`default_nettype wire

// ==== logic/scan_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_fifo (
    input  wire                 clk,
    input  wire                 rst,
    input  ps2_pkg::scan_code_t rx_code,
    input  wire                 rx_valid,
    output ps2_pkg::scan_code_t code,
    output logic                code_valid,
    input  wire                 code_ready,
    output logic                overflow
);

    import ps2_pkg::*;

    scan_code_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               push;
    logic               pop;

    assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

    // A push into a full queue is lost even if a pop happens in the same cycle.
    assign push = rx_valid & ~full;
    assign pop  = code_valid & code_ready;

    // First-word fall-through: the head entry is always on the output.
    assign code       = mem[rd_ptr];
    assign code_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sticky until reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (rx_valid && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== ps2_rx/ps2_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 ps2_clk,
    input  wire                 ps2_data,
    output ps2_pkg::scan_code_t rx_code,
    output logic                rx_valid,
    output logic                frame_error
);

    import ps2_pkg::*;

    // ==================================================
    // Synchronizers and edge detect
    // ==================================================

    // Both lines idle high, so the flops come out of reset high and no
    // false falling edge is seen.
    logic [2:0] clk_sync;
    logic [1:0] data_sync;
    logic       strobe;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // Third flop holds the old level of the clock line.
    assign strobe = clk_sync[2] & ~clk_sync[1];

    // ==================================================
    // Frame assembly
    // ==================================================

    rx_state_t                      state;
    logic [$clog2(FRAME_BITS)-1:0]  bit_cnt;
    logic [FRAME_BITS-1:0]          frame;
    logic                           frame_ok;

    // Bits enter at the top, so after a full frame frame[0] holds the start
    // bit and frame[10] the stop bit.
    always_ff @(posedge clk) begin
        if (strobe) begin
            frame <= {data_sync[1], frame[FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (strobe) begin
                        bit_cnt <= 1'b1;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (strobe) begin
                        if (bit_cnt == FRAME_BITS - 1) begin
                            bit_cnt <= '0;
                            state   <= CHECK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                CHECK: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Frame check
    // ==================================================

    // Start low, odd parity over data and parity bit, stop high.
    assign frame_ok = ~frame[0] & (^frame[9:1]) & frame[10];

    assign rx_code  = frame[8:1];
    assign rx_valid = (state == CHECK) & frame_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_error <= 1'b0;
        end else if (state == CHECK && !frame_ok) begin
            frame_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_ps2_keyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard;

    import ps2_pkg::*;
    import display_pkg::*;

    localparam int HALF_PERIOD = 12;
    localparam int NO_FAULT    = 0;
    localparam int BAD_PARITY  = 1;
    localparam int BAD_STOP    = 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic       code_ready;
    scan_code_t code;
    logic       code_valid;
    logic       overflow;
    logic       frame_error;
    seg_t       seg_lo;
    seg_t       seg_hi;

    scan_code_t expected_codes[$];
    int         checks = 0;
    int         errors = 0;
    int         pop_count = 0;
    logic [31:0] rng_state;

    ps2_keyboard_top ps2_keyboard_top_inst (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code        (code),
        .code_valid  (code_valid),
        .code_ready  (code_ready),
        .overflow    (overflow),
        .frame_error (frame_error),
        .seg_lo      (seg_lo),
        .seg_hi      (seg_hi)
    );

    always #4 clk = ~clk;

    // ==================================================
    // Reference model
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Odd parity means data and parity bit together hold an odd number of ones.
    function automatic logic odd_parity(input scan_code_t data);
        return ~(^data);
    endfunction

    // Lit segments listed as a b c d e f g, then inverted for the active-low port.
    function automatic seg_t ref_glyph(input nibble_t digit);
        logic [6:0] lit;
        case (digit)
            4'h0:    lit = 7'b1111110;
            4'h1:    lit = 7'b0110000;
            4'h2:    lit = 7'b1101101;
            4'h3:    lit = 7'b1111001;
            4'h4:    lit = 7'b0110011;
            4'h5:    lit = 7'b1011011;
            4'h6:    lit = 7'b1011111;
            4'h7:    lit = 7'b1110000;
            4'h8:    lit = 7'b1111111;
            4'h9:    lit = 7'b1111011;
            4'ha:    lit = 7'b1110111;
            4'hb:    lit = 7'b0011111;
            4'hc:    lit = 7'b1001110;
            4'hd:    lit = 7'b0111101;
            4'he:    lit = 7'b1001111;
            default: lit = 7'b1000111;
        endcase
        return ~lit;
    endfunction

    task automatic expect_value(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("MISMATCH at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // ==================================================
    // Stimulus helpers
    // ==================================================

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        wait_clocks(2);
        rst <= 1'b0;
    endtask

    // Keyboard model. Data moves one cycle after ps2_clk rises and the receiver
    // samples on the falling edge.
    task automatic send_frame(input scan_code_t data, input int fault = NO_FAULT);
        logic [FRAME_BITS-1:0] bits;
        int k;
        bits = {1'b1, odd_parity(data), data, 1'b0};
        if (fault == BAD_PARITY) begin
            bits[9] = ~bits[9];
        end
        if (fault == BAD_STOP) begin
            bits[10] = 1'b0;
        end
        for (k = 0; k < FRAME_BITS; k++) begin
            @(posedge clk);
            ps2_data <= bits[k];
            wait_clocks(HALF_PERIOD - 1);
            ps2_clk <= 1'b0;
            wait_clocks(HALF_PERIOD);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        wait_clocks(2 * HALF_PERIOD);
    endtask

    task automatic wait_for_drain(input int limit);
        int cycles;
        cycles = 0;
        while (expected_codes.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_codes.size() != 0) begin
            $display("timeout: %0d codes never came out within %0d cycles",
                     expected_codes.size(), limit);
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic wait_for_frame_error(input int limit);
        int cycles;
        cycles = 0;
        while (!frame_error && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!frame_error) begin
            $display("timeout: frame_error never rose within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic wait_for_overflow(input int limit);
        int cycles;
        cycles = 0;
        while (!overflow && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!overflow) begin
            $display("timeout: overflow never rose within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %-10s %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "FAILED", errors - errors_before);
    endtask

    // ==================================================
    // Comparing process
    // ==================================================

    logic       prev_ok = 1'b0;
    logic       prev_valid;
    logic       prev_ready;
    scan_code_t prev_code;
    scan_code_t exp_code;
    seg_t       exp_lo;
    seg_t       exp_hi;

    always @(posedge clk) begin
        if (rst) begin
            prev_ok = 1'b0;
        end else begin
            if (prev_ok) begin
                exp_lo = prev_valid ? ref_glyph(prev_code[3:0]) : SEG_BLANK;
                exp_hi = prev_valid ? ref_glyph(prev_code[7:4]) : SEG_BLANK;
                expect_value(seg_lo == exp_lo,
                             $sformatf("seg_lo %b, expected %b", seg_lo, exp_lo));
                expect_value(seg_hi == exp_hi,
                             $sformatf("seg_hi %b, expected %b", seg_hi, exp_hi));
                if (prev_valid && !prev_ready) begin
                    expect_value(code_valid && code == prev_code,
                                 $sformatf("head moved to 0x%02h from 0x%02h without a pop",
                                           code, prev_code));
                end
            end
            if (code_valid && code_ready) begin
                pop_count++;
                checks++;
                assert (expected_codes.size() != 0) else begin
                    $display("code 0x%02h came out at %0t although no frame was outstanding",
                             code, $time);
                    errors++;
                end
                if (expected_codes.size() != 0) begin
                    exp_code = expected_codes.pop_front();
                    expect_value(code == exp_code,
                                 $sformatf("code 0x%02h, expected 0x%02h", code, exp_code));
                end
            end
            prev_ok    = 1'b1;
            prev_valid = code_valid;
            prev_ready = code_ready;
            prev_code  = code;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        int         mark;
        int         pops_before;
        int         i;
        scan_code_t b;

        rst        = 1'b1;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        code_ready = 1'b0;
        rng_state  = 32'h3c4d_acfb;
        apply_reset();

        mark = errors;
        @(negedge clk);
        expect_value(code_valid == 1'b0, "code_valid high after reset");
        expect_value(overflow == 1'b0, "overflow high after reset");
        expect_value(frame_error == 1'b0, "frame_error high after reset");
        expect_value(seg_lo == SEG_BLANK, $sformatf("seg_lo %b after reset", seg_lo));
        expect_value(seg_hi == SEG_BLANK, $sformatf("seg_hi %b after reset", seg_hi));
        report_test("reset", mark);

        mark = errors;
        @(posedge clk);
        code_ready <= 1'b1;
        for (i = 0; i < 20; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            expected_codes.push_back(b);
            send_frame(b);
        end
        wait_for_drain(100);
        report_test("random", mark);

        // The error flag is sticky, so each fault kind gets a fresh reset.
        mark = errors;
        pops_before = pop_count;
        apply_reset();
        send_frame(8'h5a, BAD_PARITY);
        wait_for_frame_error(100);
        apply_reset();
        send_frame(8'hc3, BAD_STOP);
        wait_for_frame_error(100);
        @(negedge clk);
        expect_value(pop_count == pops_before, "a bad frame produced a code");
        expected_codes.push_back(8'h1c);
        send_frame(8'h1c);
        wait_for_drain(100);
        report_test("bad_frame", mark);

        mark = errors;
        pops_before = pop_count;
        @(posedge clk);
        code_ready <= 1'b0;
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            if (i < FIFO_DEPTH) begin
                expected_codes.push_back(b);
            end
            send_frame(b);
        end
        wait_for_overflow(100);
        @(negedge clk);
        expect_value(code_valid == 1'b1, "code_valid low with a full queue");
        @(posedge clk);
        code_ready <= 1'b1;
        wait_for_drain(100);
        wait_clocks(20);
        expect_value(pop_count == pops_before + FIFO_DEPTH,
                     $sformatf("%0d codes popped, expected %0d",
                               pop_count - pops_before, FIFO_DEPTH));
        report_test("overflow", mark);

        // Every digit value passes through both display positions.
        mark = errors;
        for (i = 0; i < 16; i++) begin
            b = {i[3:0], 4'hf - i[3:0]};
            expected_codes.push_back(b);
            send_frame(b);
        end
        wait_for_drain(100);
        wait_clocks(2);
        @(negedge clk);
        expect_value(code_valid == 1'b0, "code_valid high after drain");
        expect_value(seg_lo == SEG_BLANK, $sformatf("seg_lo %b after drain", seg_lo));
        expect_value(seg_hi == SEG_BLANK, $sformatf("seg_hi %b after drain", seg_hi));
        report_test("display", mark);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
